// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ntm_matrix_multiplier_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/ntm_pkg.sv
source/model_integer_multiplier.sv
vector/model_vector_integer_multiplier.sv
matrix/model_matrix_integer_multiplier.sv
source/ntm_matrix_multiplier_top.sv
testbench/ntm_matrix_multiplier_tb.sv

// ==== common/ntm_config.svh ====
`ifndef NTM_CONFIG_SVH
`define NTM_CONFIG_SVH

// Operand width
// Each half of the double-width product has this width too
`define NTM_DATA_SIZE 16

// Row, column and element counter width
// Matrix dimensions go from 1 up to 15
`define NTM_CONTROL_SIZE 4

`endif

// ==== common/ntm_pkg.sv ====
package ntm_pkg;

  //////////////////////////////
  // Matrix controller states
  //////////////////////////////

  // Wait for start, then the first element of a row, then the rest
  typedef enum logic [1:0] {
    matrix_starter = 2'd0,
    matrix_input_i = 2'd1,
    matrix_input_j = 2'd2,
    matrix_ender   = 2'd3
  } matrix_state_t;

  //////////////////////////////
  // Vector multiplier states
  //////////////////////////////

  typedef enum logic [1:0] {
    vector_idle     = 2'd0,
    vector_capture  = 2'd1,
    vector_multiply = 2'd2,
    vector_emit     = 2'd3
  } vector_state_t;

  // Scalar shift-add multiplier
  typedef enum logic {
    multiplier_idle = 1'b0,
    multiplier_busy = 1'b1
  } multiplier_state_t;

endpackage

// ==== matrix/model_matrix_integer_multiplier.sv ====
`include "ntm_config.svh"

module model_matrix_integer_multiplier
  import ntm_pkg::*;
(
  input  logic                         CLK,
  input  logic                         RST,

  // Control
  input  logic                         start,
  output logic                         ready,

  // i strobes for the first element of a row, j strobes for the rest
  input  logic                         data_a_in_i_enable,
  input  logic                         data_a_in_j_enable,
  input  logic                         data_b_in_i_enable,
  input  logic                         data_b_in_j_enable,
  output logic                         data_out_i_enable,
  output logic                         data_out_j_enable,

  // Dimensions
  input  logic [`NTM_CONTROL_SIZE-1:0] size_i_in,
  input  logic [`NTM_CONTROL_SIZE-1:0] size_j_in,

  // Operands
  input  logic [`NTM_DATA_SIZE-1:0]    data_a_in,
  input  logic [`NTM_DATA_SIZE-1:0]    data_b_in,

  // Product halves
  output logic [`NTM_DATA_SIZE-1:0]    data_out,
  output logic [`NTM_DATA_SIZE-1:0]    overflow_out
);

  localparam logic [`NTM_CONTROL_SIZE-1:0] control_one = 1;

  //////////////////////////////
  // Signals
  //////////////////////////////

  matrix_state_t                  state_int;

  // Row and column indexes
  logic [`NTM_CONTROL_SIZE-1:0]   index_i_loop;
  logic [`NTM_CONTROL_SIZE-1:0]   index_j_loop;
  logic                           last_row;
  logic                           last_column;
  logic                           row_end;

  // Per-operand flags for the current element
  logic                           data_a_flag;
  logic                           data_b_flag;
  logic                           accept_a;
  logic                           accept_b;

  // Vector multiplier side
  logic                           start_vector;
  logic                           ready_vector;
  logic                           data_a_in_enable_vector;
  logic                           data_b_in_enable_vector;
  logic                           data_out_enable_vector;
  logic [`NTM_CONTROL_SIZE-1:0]   size_in_vector;
  logic [`NTM_DATA_SIZE-1:0]      data_a_in_vector;
  logic [`NTM_DATA_SIZE-1:0]      data_b_in_vector;
  logic [`NTM_DATA_SIZE-1:0]      data_out_vector;
  logic [`NTM_DATA_SIZE-1:0]      overflow_out_vector;

  // Only the strobe kind that matches the state counts
  // First strobe of each operand wins
  assign accept_a = !data_a_flag &&
                    ((state_int == matrix_input_i && data_a_in_i_enable) ||
                     (state_int == matrix_input_j && data_a_in_j_enable));
  assign accept_b = !data_b_flag &&
                    ((state_int == matrix_input_i && data_b_in_i_enable) ||
                     (state_int == matrix_input_j && data_b_in_j_enable));

  assign last_row    = (index_i_loop == size_i_in - control_one);
  assign last_column = (index_j_loop == size_j_in - control_one);

  // Column index and vector unit both close the row
  assign row_end = last_column && ready_vector;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_int               <= matrix_starter;
      index_i_loop            <= '0;
      index_j_loop            <= '0;
      data_a_flag             <= 1'b0;
      data_b_flag             <= 1'b0;
      start_vector            <= 1'b0;
      size_in_vector          <= '0;
      data_a_in_enable_vector <= 1'b0;
      data_b_in_enable_vector <= 1'b0;
      ready                   <= 1'b0;
      data_out_i_enable       <= 1'b0;
      data_out_j_enable       <= 1'b0;
      data_out                <= '0;
      overflow_out            <= '0;
    end else begin
      // All strobes default low
      start_vector            <= 1'b0;
      data_a_in_enable_vector <= accept_a;
      data_b_in_enable_vector <= accept_b;
      ready                   <= 1'b0;
      data_out_i_enable       <= 1'b0;
      data_out_j_enable       <= 1'b0;
      case (state_int)
        matrix_starter: begin
          if (start) begin
            index_i_loop   <= '0;
            index_j_loop   <= '0;
            // Open the first row in the vector unit
            start_vector   <= 1'b1;
            size_in_vector <= size_j_in;
            state_int      <= matrix_input_i;
          end
        end
        matrix_input_i, matrix_input_j: begin
          if (accept_a) data_a_flag <= 1'b1;
          if (accept_b) data_b_flag <= 1'b1;
          if ((data_a_flag || accept_a) && (data_b_flag || accept_b)) begin
            state_int <= matrix_ender;
          end
        end
        matrix_ender: begin
          // Wait for the product of this element
          if (data_out_enable_vector) begin
            data_out          <= data_out_vector;
            overflow_out      <= overflow_out_vector;
            data_out_j_enable <= 1'b1;
            data_a_flag       <= 1'b0;
            data_b_flag       <= 1'b0;
            if (row_end && last_row) begin
              // Matrix done
              ready     <= 1'b1;
              state_int <= matrix_starter;
            end else if (row_end) begin
              // Next row, restart the vector unit
              data_out_i_enable <= 1'b1;
              index_i_loop      <= index_i_loop + control_one;
              index_j_loop      <= '0;
              start_vector      <= 1'b1;
              size_in_vector    <= size_j_in;
              state_int         <= matrix_input_i;
            end else begin
              index_j_loop <= index_j_loop + control_one;
              state_int    <= matrix_input_j;
            end
          end
        end
        default: state_int <= matrix_starter;
      endcase
    end
  end

  // Forwarded operand values, valid with their strobes
  always_ff @(posedge CLK) begin
    if (accept_a) data_a_in_vector <= data_a_in;
    if (accept_b) data_b_in_vector <= data_b_in;
  end

  //////////////////////////////
  // Vector multiplier
  //////////////////////////////

  model_vector_integer_multiplier vector_integer_multiplier (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start_vector),
    .ready           (ready_vector),
    .data_a_in_enable(data_a_in_enable_vector),
    .data_b_in_enable(data_b_in_enable_vector),
    .data_out_enable (data_out_enable_vector),
    .size_in         (size_in_vector),
    .data_a_in       (data_a_in_vector),
    .data_b_in       (data_b_in_vector),
    .data_out        (data_out_vector),
    .overflow_out    (overflow_out_vector)
  );

endmodule

// ==== source/model_integer_multiplier.sv ====
`include "ntm_config.svh"

module model_integer_multiplier
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,

  // Control
  input  logic                      start,
  output logic                      ready,

  // Operands
  input  logic [`NTM_DATA_SIZE-1:0] data_a_in,
  input  logic [`NTM_DATA_SIZE-1:0] data_b_in,

  // Low and high halves of the product
  output logic [`NTM_DATA_SIZE-1:0] data_out,
  output logic [`NTM_DATA_SIZE-1:0] overflow_out
);

  // One iteration per multiplier bit
  localparam int count_size = $clog2(`NTM_DATA_SIZE);
  localparam logic [count_size-1:0] count_last = count_size'(`NTM_DATA_SIZE - 1);

  //////////////////////////////
  // Signals
  //////////////////////////////

  multiplier_state_t             state_int;
  logic [count_size-1:0]         count_int;

  // Multiplicand widened so it can shift into the high half
  logic [2*`NTM_DATA_SIZE-1:0]   multiplicand_int;
  logic [`NTM_DATA_SIZE-1:0]     multiplier_int;
  logic [2*`NTM_DATA_SIZE-1:0]   accumulator_int;
  logic [2*`NTM_DATA_SIZE-1:0]   partial_sum;

  // Add the shifted multiplicand only for a set multiplier bit
  assign partial_sum = multiplier_int[0] ? (accumulator_int + multiplicand_int)
                                         : accumulator_int;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_int    <= multiplier_idle;
      count_int    <= '0;
      ready        <= 1'b0;
      data_out     <= '0;
      overflow_out <= '0;
    end else begin
      // Ready is a single-cycle pulse
      ready <= 1'b0;
      case (state_int)
        multiplier_idle: begin
          if (start) begin
            count_int <= '0;
            state_int <= multiplier_busy;
          end
        end
        multiplier_busy: begin
          count_int <= count_int + 1'b1;
          // Last bit, result straight from the adder
          if (count_int == count_last) begin
            data_out     <= partial_sum[`NTM_DATA_SIZE-1:0];
            overflow_out <= partial_sum[2*`NTM_DATA_SIZE-1:`NTM_DATA_SIZE];
            ready        <= 1'b1;
            state_int    <= multiplier_idle;
          end
        end
        default: state_int <= multiplier_idle;
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state_int == multiplier_idle && start) begin
      multiplicand_int <= {{`NTM_DATA_SIZE{1'b0}}, data_a_in};
      multiplier_int   <= data_b_in;
      accumulator_int  <= '0;
    end else if (state_int == multiplier_busy) begin
      // Radix-2 step
      accumulator_int  <= partial_sum;
      multiplicand_int <= multiplicand_int << 1;
      multiplier_int   <= multiplier_int >> 1;
    end
  end

endmodule

// ==== source/ntm_matrix_multiplier_top.sv ====
`include "ntm_config.svh"

module ntm_matrix_multiplier_top (
  input  logic                         CLK,
  input  logic                         RST,

  // Host control
  input  logic                         start,
  output logic                         ready,

  // Operand strobes
  input  logic                         data_a_in_i_enable,
  input  logic                         data_a_in_j_enable,
  input  logic                         data_b_in_i_enable,
  input  logic                         data_b_in_j_enable,

  // Row end and element strobes
  output logic                         data_out_i_enable,
  output logic                         data_out_j_enable,

  // Dimensions, stable until ready
  input  logic [`NTM_CONTROL_SIZE-1:0] size_i_in,
  input  logic [`NTM_CONTROL_SIZE-1:0] size_j_in,

  // Element pair
  input  logic [`NTM_DATA_SIZE-1:0]    data_a_in,
  input  logic [`NTM_DATA_SIZE-1:0]    data_b_in,

  // Low half and high half of each product
  output logic [`NTM_DATA_SIZE-1:0]    data_out,
  output logic [`NTM_DATA_SIZE-1:0]    overflow_out
);

  //////////////////////////////
  // Hadamard matrix multiplier
  //////////////////////////////

  model_matrix_integer_multiplier matrix_integer_multiplier (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .data_a_in_i_enable(data_a_in_i_enable),
    .data_a_in_j_enable(data_a_in_j_enable),
    .data_b_in_i_enable(data_b_in_i_enable),
    .data_b_in_j_enable(data_b_in_j_enable),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .size_i_in         (size_i_in),
    .size_j_in         (size_j_in),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .data_out          (data_out),
    .overflow_out      (overflow_out)
  );

endmodule

// ==== testbench/ntm_matrix_multiplier_tb.sv ====
`include "ntm_config.svh"

module ntm_matrix_multiplier_tb;

  localparam int data_size    = `NTM_DATA_SIZE;
  localparam int control_size = `NTM_CONTROL_SIZE;
  localparam int num_tests    = 7;
  localparam int hang_limit   = 40;

  // Operand modes
  localparam int mode_random = 0;
  localparam int mode_max    = 1;
  localparam int mode_small  = 2;

  typedef struct packed {
    int size_i;
    int size_j;
    int mode;
    int skew;
  } test_t;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  // Skew is b strobe time minus a strobe time
  test_t tests [num_tests] = '{
    '{1, 1, mode_small,   0},
    '{3, 4, mode_random,  0},
    '{2, 2, mode_max,     0},
    '{2, 3, mode_random, -2},
    '{3, 2, mode_random,  3},
    '{1, 5, mode_small,   1},
    '{4, 1, mode_random, -1}
  };

  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic [control_size-1:0] size_i_in;
  logic [control_size-1:0] size_j_in;
  logic [data_size-1:0]    data_a_in;
  logic [data_size-1:0]    data_b_in;
  logic                    data_a_in_i_enable;
  logic                    data_a_in_j_enable;
  logic                    data_b_in_i_enable;
  logic                    data_b_in_j_enable;
  logic                    ready;
  logic                    data_out_i_enable;
  logic                    data_out_j_enable;
  logic [data_size-1:0]    data_out;
  logic [data_size-1:0]    overflow_out;

  // Run bookkeeping
  int cycle_count = 0;
  int timeout_limit;
  int error_count;
  int test_errors;
  int failed_tests;
  int tests_run;
  int j_count;
  int i_count;
  int ready_count;
  int seed;
  bit hung;

  always #5 CLK = ~CLK;

  ntm_matrix_multiplier_top ntm_matrix_multiplier_top_inst (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .data_a_in_i_enable(data_a_in_i_enable),
    .data_a_in_j_enable(data_a_in_j_enable),
    .data_b_in_i_enable(data_b_in_i_enable),
    .data_b_in_j_enable(data_b_in_j_enable),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .size_i_in         (size_i_in),
    .size_j_in         (size_j_in),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .data_out          (data_out),
    .overflow_out      (overflow_out)
  );

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  // Output strobe counts, and no row or matrix end without an element
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_j_enable) j_count++;
      if (data_out_i_enable) i_count++;
      if (ready) ready_count++;
      assert (data_out_j_enable || !(ready || data_out_i_enable)) else begin
        $display("strobe without element: row or matrix end at time %0t", $time);
        note_error();
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got == expected) else begin
      $display("error: time %0t %s = %h, expected %h", $time, name, got, expected);
      note_error();
    end
  endtask

  task automatic pick_operands(input int mode, input int row, input int col,
                               output logic [data_size-1:0] a,
                               output logic [data_size-1:0] b);
    case (mode)
      mode_max: begin
        a = '1;
        b = '1;
      end
      mode_small: begin
        a = data_size'(row * 4 + col + 2);
        b = data_size'(col + 3);
      end
      default: begin
        a = data_size'($random(seed));
        b = data_size'($random(seed));
      end
    endcase
  endtask

  //////////////////////////////
  // Host side
  //////////////////////////////

  // i strobes for the first element of a row
  task automatic drive_element(input bit first, input logic [data_size-1:0] a,
                               input logic [data_size-1:0] b, input int skew);
    int a_at;
    int b_at;
    int step;
    a_at = (skew < 0) ? -skew : 0;
    b_at = (skew > 0) ? skew : 0;
    for (step = 0; step <= a_at + b_at; step++) begin
      @(posedge CLK);
      data_a_in_i_enable <= first && (step == a_at);
      data_a_in_j_enable <= !first && (step == a_at);
      data_b_in_i_enable <= first && (step == b_at);
      data_b_in_j_enable <= !first && (step == b_at);
      if (step == a_at) data_a_in <= a;
      if (step == b_at) data_b_in <= b;
    end
    @(posedge CLK);
    data_a_in_i_enable <= 1'b0;
    data_a_in_j_enable <= 1'b0;
    data_b_in_i_enable <= 1'b0;
    data_b_in_j_enable <= 1'b0;
  endtask

  // Wait for the element strobe and compare with the full product
  task automatic check_element(input int t, input int row, input int col,
                               input int si, input int sj,
                               input logic [data_size-1:0] a,
                               input logic [data_size-1:0] b);
    logic [2*data_size-1:0] product;
    int waited;
    bit seen;
    product = {{data_size{1'b0}}, a} * {{data_size{1'b0}}, b};
    seen = 1'b0;
    for (waited = 0; waited < hang_limit && !seen; waited++) begin
      @(negedge CLK);
      seen = data_out_j_enable;
    end
    assert (seen) else begin
      $display("hang: test %0d element (%0d,%0d) gave no output strobe within %0d cycles",
               t, row, col, hang_limit);
      note_error();
      hung = 1'b1;
    end
    if (seen) begin
      check_value("data_out", 32'(data_out), 32'(product[data_size-1:0]));
      check_value("overflow_out", 32'(overflow_out),
                  32'(product[2*data_size-1:data_size]));
      check_value("data_out_i_enable", 32'(data_out_i_enable),
                  32'(col == sj - 1 && row != si - 1));
      check_value("ready", 32'(ready), 32'(col == sj - 1 && row == si - 1));
    end
  endtask

  task automatic run_test(input int t);
    int si;
    int sj;
    int row;
    int col;
    logic [data_size-1:0] a;
    logic [data_size-1:0] b;
    si = tests[t].size_i;
    sj = tests[t].size_j;
    test_errors = 0;
    j_count = 0;
    i_count = 0;
    ready_count = 0;
    @(posedge CLK);
    start <= 1'b1;
    size_i_in <= control_size'(si);
    size_j_in <= control_size'(sj);
    @(posedge CLK);
    start <= 1'b0;
    for (row = 0; row < si && !hung; row++) begin
      for (col = 0; col < sj && !hung; col++) begin
        pick_operands(tests[t].mode, row, col, a, b);
        drive_element(col == 0, a, b, tests[t].skew);
        check_element(t, row, col, si, sj, a, b);
      end
    end
    // Room for a stray strobe after the last element
    repeat (5) @(negedge CLK);
    if (!hung) begin
      check_value("data_out_j_enable count", 32'(j_count), 32'(si * sj));
      check_value("data_out_i_enable count", 32'(i_count), 32'(si - 1));
      check_value("ready count", 32'(ready_count), 32'd1);
    end
    if (test_errors != 0) failed_tests++;
    tests_run++;
    $display("test %0d: %0dx%0d mode %0d skew %0d, %0d errors",
             t, si, sj, tests[t].mode, tests[t].skew, test_errors);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int t;
    CLK = 1'b0;
    RST = 1'b1;
    start = 1'b0;
    size_i_in = '0;
    size_j_in = '0;
    data_a_in = '0;
    data_b_in = '0;
    data_a_in_i_enable = 1'b0;
    data_a_in_j_enable = 1'b0;
    data_b_in_i_enable = 1'b0;
    data_b_in_j_enable = 1'b0;
    seed = 74849;
    error_count = 0;
    test_errors = 0;
    failed_tests = 0;
    tests_run = 0;
    hung = 1'b0;
    timeout_limit = 200;
    for (t = 0; t < num_tests; t++) begin
      timeout_limit += tests[t].size_i * tests[t].size_j * 60;
    end
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    // Idle outputs before the first start
    repeat (2) @(negedge CLK);
    check_value("ready", 32'(ready), 32'd0);
    check_value("data_out_i_enable", 32'(data_out_i_enable), 32'd0);
    check_value("data_out_j_enable", 32'(data_out_j_enable), 32'd0);
    check_value("data_out", 32'(data_out), 32'd0);
    check_value("overflow_out", 32'(overflow_out), 32'd0);
    for (t = 0; t < num_tests && !hung; t++) begin
      run_test(t);
    end
    $display("summary: %0d of %0d tests run, %0d failed, %0d errors",
             tests_run, num_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== vector/model_vector_integer_multiplier.sv ====
`include "ntm_config.svh"

module model_vector_integer_multiplier
  import ntm_pkg::*;
(
  input  logic                         CLK,
  input  logic                         RST,

  // Control
  input  logic                         start,
  output logic                         ready,

  input  logic                         data_a_in_enable,
  input  logic                         data_b_in_enable,
  output logic                         data_out_enable,

  // Row length and operands
  input  logic [`NTM_CONTROL_SIZE-1:0] size_in,
  input  logic [`NTM_DATA_SIZE-1:0]    data_a_in,
  input  logic [`NTM_DATA_SIZE-1:0]    data_b_in,

  // Product halves
  output logic [`NTM_DATA_SIZE-1:0]    data_out,
  output logic [`NTM_DATA_SIZE-1:0]    overflow_out
);

  localparam logic [`NTM_CONTROL_SIZE-1:0] control_one = 1;

  //////////////////////////////
  // Signals
  //////////////////////////////

  vector_state_t                  state_int;

  // Element counter and latched row length
  logic [`NTM_CONTROL_SIZE-1:0]   index_int;
  logic [`NTM_CONTROL_SIZE-1:0]   size_int;
  logic                           last_element;

  // Operand capture flags
  logic                           a_captured;
  logic                           b_captured;
  logic                           have_a;
  logic                           have_b;

  logic [`NTM_DATA_SIZE-1:0]      data_a_int;
  logic [`NTM_DATA_SIZE-1:0]      data_b_int;

  // Scalar multiplier side
  logic                           start_multiplier;
  logic                           ready_multiplier;
  logic [`NTM_DATA_SIZE-1:0]      data_out_multiplier;
  logic [`NTM_DATA_SIZE-1:0]      overflow_out_multiplier;

  // Operand present now or earlier in this element
  assign have_a = a_captured | data_a_in_enable;
  assign have_b = b_captured | data_b_in_enable;

  assign last_element = (index_int == size_int - control_one);

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_int        <= vector_idle;
      index_int        <= '0;
      size_int         <= '0;
      a_captured       <= 1'b0;
      b_captured       <= 1'b0;
      start_multiplier <= 1'b0;
      ready            <= 1'b0;
      data_out_enable  <= 1'b0;
      data_out         <= '0;
      overflow_out     <= '0;
    end else begin
      // Strobes last one cycle
      start_multiplier <= 1'b0;
      ready            <= 1'b0;
      data_out_enable  <= 1'b0;
      case (state_int)
        vector_idle: begin
          if (start) begin
            size_int  <= size_in;
            index_int <= '0;
            state_int <= vector_capture;
          end
        end
        vector_capture: begin
          if (data_a_in_enable) a_captured <= 1'b1;
          if (data_b_in_enable) b_captured <= 1'b1;
          // Both operands in, launch the scalar multiply
          if (have_a && have_b) begin
            a_captured       <= 1'b0;
            b_captured       <= 1'b0;
            start_multiplier <= 1'b1;
            state_int        <= vector_multiply;
          end
        end
        vector_multiply: begin
          if (ready_multiplier) begin
            data_out        <= data_out_multiplier;
            overflow_out    <= overflow_out_multiplier;
            data_out_enable <= 1'b1;
            // Row done flag rides with the last product
            ready           <= last_element;
            state_int       <= vector_emit;
          end
        end
        vector_emit: begin
          if (last_element) begin
            state_int <= vector_idle;
          end else begin
            index_int <= index_int + control_one;
            state_int <= vector_capture;
          end
        end
        default: state_int <= vector_idle;
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge CLK) begin
    if (state_int == vector_capture && data_a_in_enable) data_a_int <= data_a_in;
    if (state_int == vector_capture && data_b_in_enable) data_b_int <= data_b_in;
  end

  //////////////////////////////
  // Scalar multiplier
  //////////////////////////////

  model_integer_multiplier integer_multiplier (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start_multiplier),
    .ready       (ready_multiplier),
    .data_a_in   (data_a_int),
    .data_b_in   (data_b_int),
    .data_out    (data_out_multiplier),
    .overflow_out(overflow_out_multiplier)
  );

endmodule
